// ==== source/spi_loader_defines.svh ====
`ifndef SPI_LOADER_DEFINES_SVH
`define SPI_LOADER_DEFINES_SVH

// field widths
`define PAGE_W      12          // bubble page number
`define IMG_W       3           // image slot in flash
`define BUF_AW      15          // bubble output buffer address
`define CNT_W       12          // bit counter

// bad-loop table
`define MAP_DEPTH   4096        // one entry per loop

// flash layout
`define BOOT_PAGE   'h805       // bootloader lives here in every image
`define SPI_READ_OP 8'h03       // plain read, 24-bit address

// bit counts per phase
`define BOOT_BITS   2656        // bootloader
`define MAP_BITS    1200        // 1168 map bits + 32 trailing bits
`define PRE_BITS    6           // masked preamble before page data
`define PAGE_BITS   1030        // good loops per page

// buffer start addresses, word index x 2
`define BOOT_BASE   4106        // 2053 x 2
`define PAGE_BASE   14336       // 7168 x 2

`endif

// ==== source/spi_loader_pkg.sv ====
`default_nettype none

`include "spi_loader_defines.svh"

package spi_loader_pkg;

    typedef enum logic [4:0] {
        S_REARM,        // wait for load_req low
        S_READY,        // wait for load_req high
        S_CMD_LOAD,     // build read command
        S_CMD_CS,       // drop cs_n, first shift
        S_CMD_LO,       // command bit, sck low
        S_CMD_HI,       // command bit, sck high
        S_BOOT_INIT,    // boot phase setup
        S_MAP_INIT,     // map phase setup
        S_DAT_LO,       // data bit, sck low
        S_DAT_HI,       // data bit, sample miso
        S_DAT_WR,       // buffer strobe
        S_DAT_INC,      // bump addresses
        S_PRE_INIT,     // preamble setup
        S_PAGE_INIT,    // page setup
        S_PG_LO,        // page bit, sck low
        S_PG_RD,        // table read, sck high
        S_PG_SEL,       // pick data from mask
        S_PG_WR,        // buffer strobe
        S_PG_INC        // bump address, check loop
    } loader_state_e;

    typedef enum logic [2:0] {
        PH_CMD,
        PH_BOOT,
        PH_MAP,
        PH_PRE,
        PH_PAGE
    } load_phase_e;

    typedef logic [`BUF_AW-1:0] buf_addr_t;
    typedef logic [`PAGE_W-1:0] page_t;
    typedef logic [`CNT_W-1:0]  bit_cnt_t;

endpackage

`default_nettype wire

// ==== source/loader_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module loader_fsm
    import spi_loader_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst_n,
    input  logic        load_req,       // level request from emulator
    input  logic        page_sel,       // 0 boot load, 1 page load
    input  logic        miso,
    input  logic        limit_hit,      // current phase count reached
    input  logic        map_good,       // table entry from last read
    output logic        cs_n,
    output logic        sck,
    output logic        buf_wr_n,
    output logic        buf_wdata,
    output logic        cnt_clr,
    output logic        cnt_inc,
    output logic        addr_inc,
    output logic        map_wr,
    output logic        map_rd,
    output logic        map_inc,
    output logic        cmd_load,
    output logic        cmd_shift,
    output load_phase_e phase
);

    loader_state_e state;
    loader_state_e state_nxt;

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_REARM:
                if (!load_req)
                    state_nxt = S_READY;            // request released
            S_READY:
                if (load_req)
                    state_nxt = S_CMD_LOAD;
            S_CMD_LOAD:  state_nxt = S_CMD_CS;
            S_CMD_CS:    state_nxt = S_CMD_LO;
            S_CMD_LO:    state_nxt = S_CMD_HI;
            S_CMD_HI:
                if (!limit_hit)
                    state_nxt = S_CMD_LO;           // more command bits
                else if (page_sel)
                    state_nxt = S_PRE_INIT;
                else
                    state_nxt = S_BOOT_INIT;
            S_BOOT_INIT: state_nxt = S_DAT_LO;
            S_MAP_INIT:  state_nxt = S_DAT_LO;
            S_DAT_LO:    state_nxt = S_DAT_HI;
            S_DAT_HI:    state_nxt = S_DAT_WR;
            S_DAT_WR:    state_nxt = S_DAT_INC;
            S_DAT_INC:
                if (!limit_hit)
                    state_nxt = S_DAT_LO;
                else if (phase == PH_BOOT)
                    state_nxt = S_MAP_INIT;         // bootloader done, map follows
                else
                    state_nxt = S_REARM;            // map done, end of boot load
            S_PRE_INIT:  state_nxt = S_PG_RD;       // preamble needs no flash bits
            S_PAGE_INIT: state_nxt = S_PG_LO;
            S_PG_LO:     state_nxt = S_PG_RD;
            S_PG_RD:     state_nxt = S_PG_SEL;
            S_PG_SEL:    state_nxt = S_PG_WR;
            S_PG_WR:     state_nxt = S_PG_INC;
            S_PG_INC:
                if (!map_good)
                    state_nxt = S_PG_RD;            // bad loop, sck stays high
                else if (!limit_hit)
                    state_nxt = (phase == PH_PAGE) ? S_PG_LO : S_PG_RD;
                else if (phase == PH_PRE)
                    state_nxt = S_PAGE_INIT;
                else
                    state_nxt = S_REARM;
            default:     state_nxt = S_REARM;
        endcase
    end

    // pins follow the state they belong to, registered off next state
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            state    <= S_READY;
            phase    <= PH_CMD;
            cs_n     <= 1'b1;
            sck      <= 1'b1;
            buf_wr_n <= 1'b1;
        end
        else
        begin
            state    <= state_nxt;
            cs_n     <= (state_nxt == S_REARM) || (state_nxt == S_READY) ||
                        (state_nxt == S_CMD_LOAD);
            sck      <= !((state_nxt == S_CMD_LO) || (state_nxt == S_DAT_LO) ||
                          (state_nxt == S_PG_LO));         // falling sck shifts
            buf_wr_n <= !((state_nxt == S_DAT_WR) || (state_nxt == S_PG_WR));
            case (state_nxt)
                S_CMD_LOAD:  phase <= PH_CMD;
                S_BOOT_INIT: phase <= PH_BOOT;
                S_MAP_INIT:  phase <= PH_MAP;
                S_PRE_INIT:  phase <= PH_PRE;
                S_PAGE_INIT: phase <= PH_PAGE;
                default:     phase <= phase;
            endcase
        end
    end

    // sampled flash bit or mask result for the buffer
    always_ff @(posedge MCLK)
    begin
        if (state == S_DAT_HI)
            buf_wdata <= miso;                      // sck just rose
        else if (state == S_PG_SEL)
            buf_wdata <= map_good & ((phase == PH_PRE) ? 1'b1 : miso);  // bad loop writes 0
    end

    always_comb
    begin
        cnt_clr   = state inside {S_CMD_LOAD, S_BOOT_INIT, S_MAP_INIT,
                                  S_PRE_INIT, S_PAGE_INIT};
        cmd_load  = (state == S_CMD_LOAD);
        cmd_shift = (state == S_CMD_CS) || ((state == S_CMD_HI) && !limit_hit);
        cnt_inc   = cmd_shift || (state == S_DAT_HI) ||
                    ((state == S_PG_SEL) && map_good);       // good loops only
        addr_inc  = (state == S_DAT_INC) || (state == S_PG_INC);
        map_wr    = cmd_load || ((state == S_DAT_WR) && (phase == PH_MAP));
        map_rd    = cmd_load || (state == S_PG_RD);          // wr+rd together clears table addr
        map_inc   = ((state == S_DAT_INC) && (phase == PH_MAP)) || (state == S_PG_SEL);
    end

endmodule

`default_nettype wire

// ==== source/load_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_loader_defines.svh"

module load_counter
    import spi_loader_pkg::*;
(
    input  logic        MCLK,
    input  logic        rst_n,
    input  logic        cnt_clr,
    input  logic        cnt_inc,
    input  logic        addr_inc,
    input  logic        page_sel,       // picks page or boot base
    input  load_phase_e phase,
    output logic        limit_hit,
    output buf_addr_t   buf_waddr
);

    bit_cnt_t bit_cnt;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (cnt_clr)
            bit_cnt <= '0;
        else if (cnt_inc)
            bit_cnt <= bit_cnt + 1'b1;
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            buf_waddr <= '0;
        else if (cnt_clr && ((phase == PH_BOOT) || (phase == PH_PRE)))
            buf_waddr <= page_sel ? buf_addr_t'(`PAGE_BASE) : buf_addr_t'(`BOOT_BASE);
        else if (addr_inc)
            buf_waddr <= buf_waddr + 1'b1;  // one buffer bit per strobe
    end

    always_comb
    begin
        case (phase)
            PH_BOOT: limit_hit = (bit_cnt == bit_cnt_t'(`BOOT_BITS));
            PH_MAP:  limit_hit = (bit_cnt == bit_cnt_t'(`MAP_BITS));
            PH_PRE:  limit_hit = (bit_cnt == bit_cnt_t'(`PRE_BITS));
            PH_PAGE: limit_hit = (bit_cnt == bit_cnt_t'(`PAGE_BITS));
            default: limit_hit = bit_cnt[5];        // 32 command bits
        endcase
    end

endmodule

`default_nettype wire

// ==== source/spi_cmd_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_loader_defines.svh"

module spi_cmd_shifter
    import spi_loader_pkg::*;
(
    input  logic              MCLK,
    input  logic              rst_n,
    input  logic              cmd_load,
    input  logic              cmd_shift,
    input  logic              page_sel,       // low forces bootloader page
    input  logic [`IMG_W-1:0] img_num,
    input  page_t             page_num,
    output logic              mosi
);

    // pad bit + opcode + 24-bit address
    localparam int CMD_W = 33;

    logic [CMD_W-1:0] cmd_sr;
    page_t            cmd_page;

    assign cmd_page = page_sel ? page_num : page_t'(`BOOT_PAGE);

    // address is 00 iii pppppppppppp 0000000, 128-byte pages
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            cmd_sr <= '0;
        else if (cmd_load)
            cmd_sr <= {1'b0, `SPI_READ_OP, 2'b00, img_num, cmd_page, 7'b000_0000};
        else if (cmd_shift)
            cmd_sr <= {cmd_sr[CMD_W-2:0], 1'b0};    // msb first
    end

    assign mosi = cmd_sr[CMD_W-1];

endmodule

`default_nettype wire

// ==== source/bad_loop_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_loader_defines.svh"

module bad_loop_map
(
    input  logic MCLK,
    input  logic rst_n,
    input  logic map_wr,
    input  logic map_rd,
    input  logic map_inc,
    input  logic map_din,        // miso as sampled by the FSM
    output logic map_good        // 1 good loop, 0 bad loop
);

    localparam int AW = $clog2(`MAP_DEPTH);

    logic          map_table [`MAP_DEPTH];
    logic [AW-1:0] map_addr;
    logic [AW-1:0] wr_addr;
    logic          map_clr;

    assign map_clr = map_wr & map_rd;                       // load start marker
    assign wr_addr = {map_addr[AW-1:4], ~map_addr[3:0]};    // map is stored nibble reversed

    always_ff @(posedge MCLK)
    begin
        if (!rst_n || map_clr)
            map_addr <= '0;
        else if (map_inc)
            map_addr <= map_addr + 1'b1;
    end

    always_ff @(posedge MCLK)
    begin
        if (map_wr && !map_rd)
            map_table[wr_addr] <= map_din;
    end

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
            map_good <= 1'b0;
        else if (map_rd && !map_wr)
            map_good <= map_table[map_addr];    // plain address on read
    end

endmodule

`default_nettype wire

// ==== source/spi_loader_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_loader_defines.svh"

module spi_loader_top
    import spi_loader_pkg::*;
(
    input  logic              MCLK,
    input  logic              rst_n,
    input  logic              load_req,
    input  logic              page_sel,
    input  logic [`IMG_W-1:0] img_num,
    input  page_t             page_num,
    input  logic              miso,
    output logic              cs_n,
    output logic              sck,
    output logic              mosi,
    output logic              buf_wr_n,
    output buf_addr_t         buf_waddr,
    output logic              buf_wdata
);

    logic        cnt_clr;
    logic        cnt_inc;
    logic        addr_inc;
    logic        limit_hit;
    logic        map_wr;
    logic        map_rd;
    logic        map_inc;
    logic        map_good;
    logic        cmd_load;
    logic        cmd_shift;
    load_phase_e phase;

    loader_fsm u_fsm (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .page_sel  (page_sel),
        .miso      (miso),
        .limit_hit (limit_hit),
        .map_good  (map_good),
        .cs_n      (cs_n),
        .sck       (sck),
        .buf_wr_n  (buf_wr_n),
        .buf_wdata (buf_wdata),
        .cnt_clr   (cnt_clr),
        .cnt_inc   (cnt_inc),
        .addr_inc  (addr_inc),
        .map_wr    (map_wr),
        .map_rd    (map_rd),
        .map_inc   (map_inc),
        .cmd_load  (cmd_load),
        .cmd_shift (cmd_shift),
        .phase     (phase)
    );

    load_counter u_counter (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .cnt_clr   (cnt_clr),
        .cnt_inc   (cnt_inc),
        .addr_inc  (addr_inc),
        .page_sel  (page_sel),
        .phase     (phase),
        .limit_hit (limit_hit),
        .buf_waddr (buf_waddr)
    );

    spi_cmd_shifter u_cmd (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .cmd_load  (cmd_load),
        .cmd_shift (cmd_shift),
        .page_sel  (page_sel),
        .img_num   (img_num),
        .page_num  (page_num),
        .mosi      (mosi)
    );

    // table takes the same sampled bit that goes to the buffer
    bad_loop_map u_map (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .map_wr    (map_wr),
        .map_rd    (map_rd),
        .map_inc   (map_inc),
        .map_din   (buf_wdata),
        .map_good  (map_good)
    );

endmodule

`default_nettype wire

// ==== verif/tb_spi_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_loader_defines.svh"

module tb_spi_loader
    import spi_loader_pkg::*;
();

    localparam int CLK_HALF    = 2;         // 4 ns period
    localparam int RST_CYCLES  = 5;
    localparam int DRV_DLY     = 1;         // drive point after rising edge
    localparam int HOLD_CYCLES = 40;        // load_req kept high after a load
    localparam int IDLE_CYCLES = 20;
    localparam int SEED_INIT   = 73327;

    logic              MCLK;
    logic              rst_n;
    logic              load_req;
    logic              page_sel;
    logic [`IMG_W-1:0] img_num;
    page_t             page_num;
    logic              miso;
    logic              cs_n;
    logic              sck;
    logic              mosi;
    logic              buf_wr_n;
    buf_addr_t         buf_waddr;
    logic              buf_wdata;

    integer            seed;
    int                rnd;
    int                errors;
    int                tests_failed;
    int                watchdog_cycles;
    logic              watch_armed = 1'b0;

    logic              t_sel [$];        // test table from the data file
    logic [`IMG_W-1:0] t_img [$];
    page_t             t_page [$];
    logic [31:0]       t_cmd [$];
    int                t_writes [$];

    int                rise_cnt;         // flash side, sck rises since cs_n fell
    logic [31:0]       cmd_rx;
    logic              boot_mode;
    logic              flash_q [$];      // every bit the flash sent this load
    logic              map_q [$];        // map bits of the last boot load
    buf_addr_t         wr_addr_q [$];
    logic              wr_data_q [$];
    logic              strobe_prev;

    spi_loader_top u_dut (
        .MCLK      (MCLK),
        .rst_n     (rst_n),
        .load_req  (load_req),
        .page_sel  (page_sel),
        .img_num   (img_num),
        .page_num  (page_num),
        .miso      (miso),
        .cs_n      (cs_n),
        .sck       (sck),
        .mosi      (mosi),
        .buf_wr_n  (buf_wr_n),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #CLK_HALF MCLK = ~MCLK;
    end

    // flash model, command in on rising sck
    always @(negedge cs_n)
    begin
        rise_cnt = 0;
        cmd_rx   = '0;
    end

    always @(posedge sck)
    begin
        if (!cs_n && rise_cnt < 32)
        begin
            cmd_rx   = {cmd_rx[30:0], mosi};     // msb first
            rise_cnt = rise_cnt + 1;
        end
    end

    // data out on falling sck once the command is in
    always @(negedge sck)
    begin
        if (!cs_n && rise_cnt == 32)
        begin
            #DRV_DLY;
            rnd = $random(seed);
            if (boot_mode && flash_q.size() >= `BOOT_BITS)
                miso = (rnd[3:0] != 4'd0);        // map bits, mostly good loops
            else
                miso = rnd[0];
            flash_q.push_back(miso);
        end
    end

    // buffer monitor
    always @(posedge MCLK)
    begin
        if (rst_n && !buf_wr_n)
        begin
            wr_addr_q.push_back(buf_waddr);
            wr_data_q.push_back(buf_wdata);
            if (strobe_prev)
            begin
                $display("buf_wr_n stayed low for more than one cycle at %0t", $time);
                errors = errors + 1;
            end
        end
        strobe_prev = rst_n && !buf_wr_n;
    end

    initial
    begin
        wait (watch_armed);
        repeat (watchdog_cycles) @(posedge MCLK);
        $display("watchdog expired after %0d cycles, load never finished", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic clock_step();
        @(posedge MCLK);
        #DRV_DLY;
    endtask

    task automatic run_load(input int idx);
        int   err0;
        int   n_wr;
        int   n_flash;
        int   base;
        int   good;
        int   j;
        logic restarted;
        logic mbit;
        logic exp_q [$];
        err0      = errors;
        restarted = 1'b0;
        wr_addr_q.delete();
        wr_data_q.delete();
        flash_q.delete();
        boot_mode = !t_sel[idx];
        page_sel  = t_sel[idx];
        img_num   = t_img[idx];
        page_num  = t_page[idx];
        load_req  = 1'b1;
        @(posedge MCLK);
        while (cs_n)
            @(posedge MCLK);                    // load starts
        while (!cs_n)
            @(posedge MCLK);                    // cs_n high ends it
        n_wr = wr_addr_q.size();
        repeat (HOLD_CYCLES)
        begin
            @(posedge MCLK);
            if (!cs_n)
                restarted = 1'b1;
        end
        if (restarted || wr_addr_q.size() != n_wr)
        begin
            $display("a second load started while load_req stayed high");
            errors = errors + 1;
        end
        #DRV_DLY;
        load_req = 1'b0;
        clock_step();
        clock_step();
        if (cmd_rx !== t_cmd[idx])
        begin
            $display("ERR mosi command exp %h got %h", t_cmd[idx], cmd_rx);
            errors = errors + 1;
        end
        n_flash = t_sel[idx] ? t_writes[idx] - `PRE_BITS : t_writes[idx];
        if (flash_q.size() != n_flash)
        begin
            $display("ERR miso bit count exp %h got %h", n_flash, flash_q.size());
            errors = errors + 1;
        end
        if (!t_sel[idx])
        begin
            base  = `BOOT_BASE;
            exp_q = flash_q;                    // boot writes mirror the flash
            map_q.delete();
            for (j = `BOOT_BITS; j < flash_q.size(); j++)
                map_q.push_back(flash_q[j]);
        end
        else
        begin
            base = `PAGE_BASE;
            good = 0;
            j    = 0;
            while (good < t_writes[idx] && j < map_q.size())
            begin
                mbit = map_q[j ^ 15];           // table stored nibble reversed
                if (good < `PRE_BITS)
                    exp_q.push_back(mbit);
                else if (mbit && good - `PRE_BITS < flash_q.size())
                    exp_q.push_back(flash_q[good - `PRE_BITS]);
                else
                    exp_q.push_back(1'b0);      // bad loop fill
                if (mbit)
                    good = good + 1;
                j = j + 1;
            end
            if (good < t_writes[idx])
            begin
                $display("bad-loop map ran out before the page was complete");
                errors = errors + 1;
            end
        end
        if (wr_addr_q.size() != exp_q.size())
        begin
            $display("ERR buf_wr_n count exp %h got %h", exp_q.size(), wr_addr_q.size());
            errors = errors + 1;
        end
        for (j = 0; j < wr_addr_q.size() && j < exp_q.size(); j++)
        begin
            if (wr_addr_q[j] !== buf_addr_t'(base + j))
            begin
                $display("ERR buf_waddr exp %h got %h", buf_addr_t'(base + j), wr_addr_q[j]);
                errors = errors + 1;
                break;
            end
            if (wr_data_q[j] !== exp_q[j])
            begin
                $display("ERR buf_wdata at %h exp %h got %h", wr_addr_q[j], exp_q[j],
                         wr_data_q[j]);
                errors = errors + 1;
                break;
            end
        end
        if (errors != err0)
            tests_failed = tests_failed + 1;
        $display("test %0d %s load img %h page %h: %0d writes, %s", idx + 1,
                 t_sel[idx] ? "page" : "boot", t_img[idx], t_page[idx],
                 wr_addr_q.size(), (errors == err0) ? "ok" : "failed");
    endtask

    initial
    begin
        int          fd;
        int          n;
        int          sel;
        int          img;
        int          pg;
        int          cnt;
        int          total;
        int          i;
        int          err0;
        logic [31:0] cmd;
        string       line;
        rst_n        = 1'b0;
        load_req     = 1'b0;
        page_sel     = 1'b0;
        img_num      = '0;
        page_num     = '0;
        miso         = 1'b0;
        seed         = SEED_INIT;
        errors       = 0;
        tests_failed = 0;
        total        = 0;
        rise_cnt     = 0;
        cmd_rx       = '0;
        boot_mode    = 1'b0;
        strobe_prev  = 1'b0;
        fd = $fopen("verif/spi_loader_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verif/spi_loader_testdata.txt");
            errors = errors + 1;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0)
                begin
                    n = $sscanf(line, "%d %h %h %h %d", sel, img, pg, cmd, cnt);
                    if (n == 5)                 // comment lines fall out here
                    begin
                        t_sel.push_back(sel[0]);
                        t_img.push_back(img[`IMG_W-1:0]);
                        t_page.push_back(pg[`PAGE_W-1:0]);
                        t_cmd.push_back(cmd);
                        t_writes.push_back(cnt);
                        total = total + cnt;
                    end
                end
            end
            $fclose(fd);
        end
        if (t_sel.size() == 0)
        begin
            $display("no tests found in the data file");
            errors = errors + 1;
        end
        watchdog_cycles = total * 12 + t_sel.size() * (HOLD_CYCLES + 600) + 1000;
        watch_armed     = 1'b1;

        repeat (RST_CYCLES) @(posedge MCLK);
        #DRV_DLY;
        rst_n = 1'b1;
        err0  = errors;
        repeat (IDLE_CYCLES)
        begin
            @(posedge MCLK);
            if (cs_n !== 1'b1 || sck !== 1'b1 || buf_wr_n !== 1'b1)
            begin
                $display("ERR cs_n/sck/buf_wr_n exp 1/1/1 got %h/%h/%h", cs_n, sck, buf_wr_n);
                errors = errors + 1;
            end
        end
        if (wr_addr_q.size() != 0)
        begin
            $display("buffer written while load_req was low");
            errors = errors + 1;
        end
        if (errors != err0)
            tests_failed = tests_failed + 1;
        $display("test 0 reset idle: %s", (errors == err0) ? "ok" : "failed");
        #DRV_DLY;

        for (i = 0; i < t_sel.size(); i++)
            run_load(i);

        $display("%0d tests run, %0d failed, %0d errors", t_sel.size() + 1, tests_failed,
                 errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/spi_loader_pkg.sv
source/loader_fsm.sv
source/load_counter.sv
source/spi_cmd_shifter.sv
source/bad_loop_map.sv
source/spi_loader_top.sv
verif/tb_spi_loader.sv

// ==== Makefile ====
TOP = tb_spi_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module spi_loader_top

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== verif/spi_loader_testdata.txt ====
# page_sel img_num page_num command writes
# img_num, page_num, command in hex; writes in decimal, bad-loop fills not counted
0 2 123 03140280 3856
1 2 123 03109180 1036
1 2 fff 0317ff80 1036
0 5 3a0 032c0280 3856
1 5 001 03280080 1036
